/* design/serdes_pkg.sv */
package serdes_pkg;

    // sample path
    localparam int sample_w = 9;                      // signed voltage sample width
    typedef logic signed [sample_w-1:0] sample_t;
    localparam int level_step = 56;                   // gap between adjacent pam4 levels

    typedef logic [1:0] symbol_t;                     // 0 is the lowest level

    // post-cursor tap, a fraction in 64ths
    localparam int tap_w = 8;
    typedef logic signed [tap_w-1:0] tap_t;
    localparam int tap_shift = 6;

    // prbs31, x^31 + x^28 + 1
    localparam logic [30:0] prbs_seed = 31'b1101000101011010010010100011111;
    localparam int prbs_tap_a = 30;
    localparam int prbs_tap_b = 27;

    localparam int count_w = 32;                      // bit and error counters
    typedef logic [count_w-1:0] count_t;

    // apb register map
    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;
    localparam logic [apb_addr_w-1:0] addr_ctrl      = 8'h00;
    localparam logic [apb_addr_w-1:0] addr_chan_tap  = 8'h04;
    localparam logic [apb_addr_w-1:0] addr_dfe_tap   = 8'h08;
    localparam logic [apb_addr_w-1:0] addr_bit_count = 8'h0C; // read only
    localparam logic [apb_addr_w-1:0] addr_err_count = 8'h10; // read only

    // symbol index to level: -84, -28, 28, 84
    function automatic sample_t sym_to_level(symbol_t sym);
        return sample_t'(int'(sym) * level_step - (3 * level_step) / 2);
    endfunction

endpackage

/* design/link_ctrl_if.sv */
interface link_ctrl_if;
    import serdes_pkg::*;

    logic   enable;     // transmitter runs while high
    logic   clear;      // one cycle pulse, zeroes counters
    logic   inject;     // one cycle pulse, flips next tx bit
    tap_t   chan_tap;   // channel post-cursor
    tap_t   dfe_tap;    // receiver feedback tap
    count_t bit_count;  // received bits
    count_t err_count;  // mismatches

    modport regs (output enable, clear, inject, chan_tap, dfe_tap,
                  input  bit_count, err_count);
    modport tx   (input enable, inject);
    modport chan (input chan_tap);
    modport rx   (input dfe_tap);
    modport chk  (input clear, output bit_count, err_count);

endinterface

/* design/link_regs.sv */
module link_regs (
    input  logic                              clock,
    input  logic                              reset_n,
    input  logic [serdes_pkg::apb_addr_w-1:0] paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [serdes_pkg::apb_data_w-1:0] pwdata,
    output logic [serdes_pkg::apb_data_w-1:0] prdata,
    output logic                              pready,
    output logic                              pslverr,
    link_ctrl_if.regs                         ctrl
);
    import serdes_pkg::*;

    logic access;     // second cycle of a transfer
    logic mapped;     // address hits the map
    logic read_only;  // counter addresses
    logic wr_ok;      // write that actually lands

    assign access = psel & penable;

    assign read_only = (paddr == addr_bit_count) || (paddr == addr_err_count);
    assign mapped    = read_only
                    || (paddr == addr_ctrl)
                    || (paddr == addr_chan_tap)
                    || (paddr == addr_dfe_tap);

    assign wr_ok = access & pwrite & mapped & ~read_only;

    // no wait states
    assign pready = 1'b1;

    // flagged only in the access phase
    assign pslverr = access & (~mapped | (pwrite & read_only));

    // read mux, combinational so data is there in the access phase
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                addr_ctrl:      prdata = {{(apb_data_w-1){1'b0}}, ctrl.enable}; // pulses read 0
                addr_chan_tap:  prdata = {{(apb_data_w-tap_w){ctrl.chan_tap[tap_w-1]}},
                                          ctrl.chan_tap};
                addr_dfe_tap:   prdata = {{(apb_data_w-tap_w){ctrl.dfe_tap[tap_w-1]}},
                                          ctrl.dfe_tap};
                addr_bit_count: prdata = apb_data_w'(ctrl.bit_count);
                addr_err_count: prdata = apb_data_w'(ctrl.err_count);
                default:        prdata = '0;                         // unmapped
            endcase
        end
    end

    // control and tap registers
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            ctrl.enable   <= 1'b0;
            ctrl.clear    <= 1'b0;
            ctrl.inject   <= 1'b0;
            ctrl.chan_tap <= '0;
            ctrl.dfe_tap  <= '0;
        end else begin
            ctrl.clear  <= 1'b0; // self clearing
            ctrl.inject <= 1'b0;
            if (wr_ok) begin
                case (paddr)
                    addr_ctrl: begin
                        ctrl.enable <= pwdata[0];
                        ctrl.clear  <= pwdata[1]; // pulse next cycle
                        ctrl.inject <= pwdata[2];
                    end
                    addr_chan_tap: ctrl.chan_tap <= tap_t'(pwdata[tap_w-1:0]);
                    addr_dfe_tap:  ctrl.dfe_tap  <= tap_t'(pwdata[tap_w-1:0]);
                    default: ;                    // counters are not writable
                endcase
            end
        end
    end

endmodule

/* design/pam4_transmitter.sv */
module pam4_transmitter (
    input  logic                clock,
    input  logic                reset_n,
    link_ctrl_if.tx             ctrl,
    output serdes_pkg::sample_t level,
    output logic                level_valid
);
    import serdes_pkg::*;

    logic [30:0] prbs_sr;     // generator state
    logic        prbs_bit;    // next raw bit
    logic        tx_bit;      // bit after optional flip
    logic        inject_pend; // armed by ctrl.inject
    logic        first_bit;   // first bit of the pair
    logic        half;        // first bit is held
    symbol_t     sym;         // gray coded pair

    assign prbs_bit = prbs_sr[prbs_tap_a] ^ prbs_sr[prbs_tap_b];
    assign tx_bit   = prbs_bit ^ inject_pend;  // flip leaves prbs_sr untouched

    // gray: 00->0, 01->1, 11->2, 10->3
    assign sym = {first_bit, first_bit ^ tx_bit};

    // prbs31 stepper
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            prbs_sr <= prbs_seed;
        end else if (ctrl.enable) begin
            prbs_sr <= {prbs_sr[29:0], prbs_bit};
        end
    end

    // one flip per inject request
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            inject_pend <= 1'b0;
        end else begin
            // consumed by the next enabled cycle
            inject_pend <= ctrl.inject | (inject_pend & ~ctrl.enable);
        end
    end

    // pair bits into symbols
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            half        <= 1'b0;
            level_valid <= 1'b0;
        end else begin
            level_valid <= 1'b0;
            if (ctrl.enable) begin
                half <= ~half;
                if (half) begin
                    level_valid <= 1'b1;           // one strobe per pair
                end
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clock) begin
        if (ctrl.enable) begin
            if (!half) begin
                first_bit <= tx_bit;
            end else begin
                level <= sym_to_level(sym);
            end
        end
    end

endmodule

/* design/isi_channel.sv */
module isi_channel (
    input  logic                clock,
    input  logic                reset_n,
    link_ctrl_if.chan           ctrl,
    input  serdes_pkg::sample_t level,
    input  logic                level_valid,
    output serdes_pkg::sample_t sample,
    output logic                sample_valid
);
    import serdes_pkg::*;

    sample_t                          prev_level; // last symbol sent
    logic signed [sample_w+tap_w-1:0] isi_prod;   // prev * tap, full width
    sample_t                          isi_term;   // scaled post-cursor
    sample_t                          isi_sum;

    // post-cursor from the previous symbol
    assign isi_prod = prev_level * ctrl.chan_tap;
    assign isi_term = sample_t'(isi_prod >>> tap_shift); // arithmetic, floors

    // bounded below 255, fits sample_t without clipping
    assign isi_sum = level + isi_term;

    // symbol memory, zero at start so first symbol sees no isi
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            prev_level <= '0;
        end else if (level_valid) begin
            prev_level <= level;
        end
    end

    // output register stage
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= level_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (level_valid) begin
            sample <= isi_sum;
        end
    end

endmodule

/* design/pam4_receiver.sv */
module pam4_receiver (
    input  logic                clock,
    input  logic                reset_n,
    link_ctrl_if.rx             ctrl,
    input  serdes_pkg::sample_t sample,
    input  logic                sample_valid,
    output logic                bit_out,
    output logic                bit_valid
);
    import serdes_pkg::*;

    sample_t                          prev_dec;   // last decided level
    logic signed [sample_w+tap_w-1:0] fb_prod;
    sample_t                          fb_term;    // same scaling as channel
    logic signed [sample_w:0]         eq;         // one extra bit, mismatched taps
    symbol_t                          sym;
    logic                             second_bit; // held for the next cycle
    logic                             second_pend;

    // decision feedback
    assign fb_prod = prev_dec * ctrl.dfe_tap;
    assign fb_term = sample_t'(fb_prod >>> tap_shift);
    assign eq      = sample - fb_term;

    // slicer at -56, 0, 56
    always_comb begin
        if (eq < -level_step) begin
            sym = 2'd0;
        end else if (eq < 0) begin
            sym = 2'd1;
        end else if (eq < level_step) begin
            sym = 2'd2;
        end else begin
            sym = 2'd3;
        end
    end

    // feedback memory
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            prev_dec <= '0;
        end else if (sample_valid) begin
            prev_dec <= sym_to_level(sym);
        end
    end

    // serializer, first bit goes out straight away
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            bit_valid   <= 1'b0;
            second_pend <= 1'b0;
        end else begin
            bit_valid   <= sample_valid | second_pend;
            second_pend <= sample_valid;  // symbols are at least two cycles apart
        end
    end

    always_ff @(posedge clock) begin
        if (sample_valid) begin
            bit_out    <= sym[1];            // gray decode, first bit
            second_bit <= sym[1] ^ sym[0];   // second bit
        end else if (second_pend) begin
            bit_out <= second_bit;
        end
    end

endmodule

/* design/prbs_checker.sv */
module prbs_checker (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     bit_in,
    input  logic     bit_valid,
    link_ctrl_if.chk ctrl
);
    import serdes_pkg::*;

    logic [30:0] ref_sr;   // reference prbs31
    logic        ref_bit;  // expected next bit
    logic        mismatch;

    assign ref_bit  = ref_sr[prbs_tap_a] ^ ref_sr[prbs_tap_b];
    assign mismatch = bit_in ^ ref_bit;

    // steps only on received bits, stays aligned across gaps
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            ref_sr <= prbs_seed;
        end else if (bit_valid) begin
            ref_sr <= {ref_sr[29:0], ref_bit};
        end
    end

    // counters, saturating; clear wins over a count
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            ctrl.bit_count <= '0;
            ctrl.err_count <= '0;
        end else if (ctrl.clear) begin
            ctrl.bit_count <= '0;  // sequence keeps running
            ctrl.err_count <= '0;
        end else if (bit_valid) begin
            if (~&ctrl.bit_count) begin
                ctrl.bit_count <= ctrl.bit_count + 1'b1;
            end
            if (mismatch && ~&ctrl.err_count) begin
                ctrl.err_count <= ctrl.err_count + 1'b1;
            end
        end
    end

endmodule

/* design/serdes_link_top.sv */
module serdes_link_top (
    input  logic                              clock,
    input  logic                              reset_n,
    input  logic [serdes_pkg::apb_addr_w-1:0] paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [serdes_pkg::apb_data_w-1:0] pwdata,
    output logic [serdes_pkg::apb_data_w-1:0] prdata,
    output logic                              pready,
    output logic                              pslverr
);
    import serdes_pkg::*;

    sample_t level;         // tx -> channel
    logic    level_valid;
    sample_t sample;        // channel -> rx
    logic    sample_valid;
    logic    rx_bit;        // rx -> checker
    logic    rx_bit_valid;

    link_ctrl_if ctrl_if ();

    link_regs regs_i (
        .clock   (clock),
        .reset_n (reset_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ctrl    (ctrl_if.regs)
    );

    pam4_transmitter tx_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .ctrl        (ctrl_if.tx),
        .level       (level),
        .level_valid (level_valid)
    );

    isi_channel chan_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .ctrl         (ctrl_if.chan),
        .level        (level),
        .level_valid  (level_valid),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    pam4_receiver rx_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .ctrl         (ctrl_if.rx),
        .sample       (sample),
        .sample_valid (sample_valid),
        .bit_out      (rx_bit),
        .bit_valid    (rx_bit_valid)
    );

    prbs_checker chk_i (
        .clock     (clock),
        .reset_n   (reset_n),
        .bit_in    (rx_bit),
        .bit_valid (rx_bit_valid),
        .ctrl      (ctrl_if.chk)
    );

endmodule

/* verification/serdes_link_props.sv */
module serdes_link_props (
    input logic                clock,
    input logic                reset_n,
    input logic                psel,
    input logic                penable,
    input logic                pready,
    input logic                pslverr,
    input logic                level_valid,
    input logic                bit_valid,
    input logic                clear,
    input serdes_pkg::count_t  bit_count,
    input serdes_pkg::count_t  err_count
);
    import serdes_pkg::*;

    int unsigned fail_count = 0;  // read by the testbench at the end

    count_t tx_symbols;  // level strobes since reset
    count_t rx_bits;     // bit strobes since reset

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            tx_symbols <= '0;
            rx_bits    <= '0;
        end else begin
            if (level_valid) begin
                tx_symbols <= tx_symbols + 1'b1;
            end
            if (bit_valid) begin
                rx_bits <= rx_bits + 1'b1;
            end
        end
    end

    // zero wait states, always
    pready_high: assert property (@(posedge clock) pready)
        else begin $error("pready went low"); fail_count++; end

    // error flag only in the second half of a transfer
    slverr_in_access: assert property (@(posedge clock) disable iff (!reset_n)
        pslverr |-> (psel && penable))
        else begin $error("pslverr outside an access phase"); fail_count++; end

    // two bits out per symbol in, never more
    bits_follow_symbols: assert property (@(posedge clock) disable iff (!reset_n)
        {1'b0, rx_bits} <= {tx_symbols, 1'b0})
        else begin $error("receiver produced more bits than symbols sent"); fail_count++; end

    errors_below_bits: assert property (@(posedge clock) disable iff (!reset_n)
        err_count <= bit_count)
        else begin $error("err_count above bit_count"); fail_count++; end

    // clear wins over counting
    clear_zeroes: assert property (@(posedge clock) disable iff (!reset_n)
        clear |=> (bit_count == '0 && err_count == '0))
        else begin $error("counters not zero after clear"); fail_count++; end

endmodule

bind serdes_link_top serdes_link_props props_i (
    .clock       (clock),
    .reset_n     (reset_n),
    .psel        (psel),
    .penable     (penable),
    .pready      (pready),
    .pslverr     (pslverr),
    .level_valid (level_valid),
    .bit_valid   (rx_bit_valid),
    .clear       (ctrl_if.clear),
    .bit_count   (ctrl_if.bit_count),
    .err_count   (ctrl_if.err_count)
);

/* verification/serdes_link_tb.sv */
module serdes_link_tb;
    import serdes_pkg::*;

    logic        clock;
    logic        reset_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    integer      seed = 32'he33c_be67;
    int          value_errors = 0;
    int          timeout_errors = 0;
    tap_t        tap_a;         // register readback taps
    tap_t        tap_b;
    tap_t        tap_m;         // shared channel and dfe tap
    logic [31:0] rd;

    serdes_link_top dut_i (
        .clock   (clock),
        .reset_n (reset_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #4 clock = ~clock;  // period 8

    task automatic report_and_finish;
        int total;
        total = value_errors + timeout_errors + dut_i.props_i.fail_count;
        $display("errors: %0d value, %0d timeout, %0d assertion",
                 value_errors, timeout_errors, dut_i.props_i.fail_count);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: %s expected %0d actual %0d", test, what, expected, actual);
            value_errors++;
        end
    endtask

    // one apb transfer driven on falling edges
    task automatic bus_transfer(input logic wr, input logic [7:0] addr,
                                input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic slverr);
        int waited;
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clock);
        penable = 1'b1;
        waited  = 0;
        #1;                                        // outputs settled
        while (!pready && waited < 16) begin
            @(negedge clock);
            #1;
            waited++;
        end
        if (!pready) begin
            $display("timeout: pready never came for address %02h", addr);
            timeout_errors++;
            rdata  = '0;
            slverr = 1'b0;
        end else begin
            rdata  = prdata;
            slverr = pslverr;
        end
        @(negedge clock);                          // access completes on the rising edge
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input string test, input logic [7:0] addr,
                             input logic [31:0] data, input logic exp_err);
        logic [31:0] unused;
        logic        slverr;
        bus_transfer(1'b1, addr, data, unused, slverr);
        check_value(test, "pslverr on write", exp_err, slverr);
    endtask

    task automatic read_reg(input string test, input logic [7:0] addr,
                            output logic [31:0] data, input logic exp_err);
        logic slverr;
        bus_transfer(1'b0, addr, 32'h0, data, slverr);
        check_value(test, "pslverr on read", exp_err, slverr);
    endtask

    task automatic expect_reg(input string test, input string what,
                              input logic [7:0] addr, input logic [31:0] expected);
        logic [31:0] data;
        read_reg(test, addr, data, 1'b0);
        check_value(test, what, expected, data);
    endtask

    // enable then disable and let the pipeline empty
    task automatic run_link(input string test, input int cycles);
        write_reg(test, addr_ctrl, 32'h1, 1'b0);
        repeat (cycles) @(negedge clock);
        write_reg(test, addr_ctrl, 32'h0, 1'b0);
        repeat (32) @(negedge clock);              // drain
    endtask

    initial begin
        clock   = 1'b0;
        reset_n = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (8) @(negedge clock);
        reset_n = 1'b1;

        tap_a = tap_t'(8 + ($unsigned($random(seed)) % 33));  // 8 to 40
        tap_b = tap_t'(8 + ($unsigned($random(seed)) % 33));
        tap_m = tap_t'(8 + ($unsigned($random(seed)) % 33));

        // register access and error responses
        write_reg("regs", addr_chan_tap, 32'(tap_a), 1'b0);
        write_reg("regs", addr_dfe_tap, 32'(tap_b), 1'b0);
        expect_reg("regs", "chan_tap", addr_chan_tap, 32'(tap_a));
        expect_reg("regs", "dfe_tap", addr_dfe_tap, 32'(tap_b));
        write_reg("regs", addr_bit_count, 32'h1234, 1'b1);   // read only
        write_reg("regs", 8'h20, 32'h55, 1'b1);              // unmapped
        read_reg("regs", 8'h20, rd, 1'b1);
        expect_reg("regs", "chan_tap kept", addr_chan_tap, 32'(tap_a));
        expect_reg("regs", "dfe_tap kept", addr_dfe_tap, 32'(tap_b));
        expect_reg("regs", "bit_count kept", addr_bit_count, 32'h0);
        expect_reg("regs", "ctrl idle", addr_ctrl, 32'h0);

        // clean link without isi
        write_reg("clean", addr_chan_tap, 32'h0, 1'b0);
        write_reg("clean", addr_dfe_tap, 32'h0, 1'b0);
        write_reg("clean", addr_ctrl, 32'h2, 1'b0);          // clear
        run_link("clean", 2000);
        read_reg("clean", addr_bit_count, rd, 1'b0);
        check_value("clean", "bit_count even", 32'h0, rd[0]);
        check_value("clean", "bit_count nonzero", 32'h1, rd != 0);
        expect_reg("clean", "err_count", addr_err_count, 32'h0);

        // post-cursor cancelled exactly by a matched dfe
        write_reg("matched_dfe", addr_chan_tap, 32'(tap_m), 1'b0);
        write_reg("matched_dfe", addr_dfe_tap, 32'(tap_m), 1'b0);
        write_reg("matched_dfe", addr_ctrl, 32'h2, 1'b0);
        run_link("matched_dfe", 2000);
        read_reg("matched_dfe", addr_bit_count, rd, 1'b0);
        check_value("matched_dfe", "bit_count nonzero", 32'h1, rd != 0);
        expect_reg("matched_dfe", "err_count", addr_err_count, 32'h0);

        // single flipped bit with the same taps
        write_reg("inject", addr_ctrl, 32'h2, 1'b0);
        write_reg("inject", addr_ctrl, 32'h1, 1'b0);
        repeat (300) @(negedge clock);
        write_reg("inject", addr_ctrl, 32'h5, 1'b0);         // inject while enable stays on
        repeat (300) @(negedge clock);
        write_reg("inject", addr_ctrl, 32'h0, 1'b0);
        repeat (32) @(negedge clock);
        expect_reg("inject", "err_count", addr_err_count, 32'h1);

        // isi beyond the slicer margin without dfe
        write_reg("no_dfe", addr_chan_tap, 32'd40, 1'b0);
        write_reg("no_dfe", addr_dfe_tap, 32'h0, 1'b0);
        write_reg("no_dfe", addr_ctrl, 32'h2, 1'b0);
        run_link("no_dfe", 2000);
        read_reg("no_dfe", addr_err_count, rd, 1'b0);
        check_value("no_dfe", "err_count nonzero", 32'h1, rd != 0);
        write_reg("no_dfe", addr_ctrl, 32'h2, 1'b0);
        expect_reg("no_dfe", "bit_count cleared", addr_bit_count, 32'h0);
        expect_reg("no_dfe", "err_count cleared", addr_err_count, 32'h0);

        report_and_finish;
    end

endmodule

/* all.f */
design/serdes_pkg.sv
design/link_ctrl_if.sv
design/link_regs.sv
design/pam4_transmitter.sv
design/isi_channel.sv
design/pam4_receiver.sv
design/prbs_checker.sv
design/serdes_link_top.sv
verification/serdes_link_props.sv
verification/serdes_link_tb.sv
